/* common/fe_macros.svh */
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Byte address width for fetch and the memory port
`define FE_ADDR_W 32

// Instruction memory depth in 32-bit words
`define FE_MEM_WORDS 256

// First fetch address after reset
`define FE_RESET_PC 32'h0000_0000

// Everything here is sized for RV32 without compressed instructions

`endif

/* common/fe_pkg.sv */
`include "fe_macros.svh"

package fe_pkg;

    typedef logic [`FE_ADDR_W-1:0] t_paddr;

    // Request strobe to instruction memory
    typedef struct packed {
        logic   valid;
        t_paddr addr;
    } t_fe_req;

    // Memory response, one cycle after the request
    typedef struct packed {
        logic        valid;
        t_paddr      pc;
        logic [31:0] instr;
    } t_mem_rsp;

    // I-type layout, also used for the common fields
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_rv_i_view;

    // S and B formats share this split of the immediate
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } t_rv_sb_view;

    typedef union packed {
        t_rv_i_view  i_type;
        t_rv_sb_view sb_type;
    } t_rv_instr;

    typedef struct packed {
        t_paddr    pc;
        t_rv_instr instr;
    } t_fetch_pkt;

    typedef struct packed {
        t_paddr      pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } t_decoded;

    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

endpackage

/* fetch/fetch_ctl.sv */
`include "fe_macros.svh"

module fetch_ctl (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               redirect,
    input  fe_pkg::t_paddr     redirect_pc,
    output fe_pkg::t_fe_req    fe_req,
    input  fe_pkg::t_mem_rsp   mem_rsp,
    output logic               fe_valid,
    output logic               halted,
    output fe_pkg::t_fetch_pkt fe_pkt
);
    import fe_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_PENDING,
        ST_PENDING_STALL,
        ST_DRAIN,
        ST_HALT
    } t_fe_state;

    t_fe_state  state;
    t_fe_state  state_nxt;
    t_paddr     pc;
    t_fetch_pkt live_pkt;
    t_fetch_pkt hold_pkt;
    logic       take_redirect;
    logic       halt;

    // Redirects are ignored once the front end is shutting down
    assign take_redirect = redirect && state != ST_DRAIN && state != ST_HALT;

    assign live_pkt.pc    = mem_rsp.pc;
    assign live_pkt.instr = t_rv_instr'(mem_rsp.instr);

    // SYSTEM opcode on a live response stops fetch
    assign halt = state == ST_PENDING && mem_rsp.valid && !take_redirect
                  && live_pkt.instr.i_type.opcode == OP_SYSTEM;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: state_nxt = ST_REQ;
            ST_REQ: state_nxt = ST_PENDING;
            ST_PENDING: begin
                // Without stall the response goes out early and we stay here
                if (mem_rsp.valid && stall) begin
                    state_nxt = ST_PENDING_STALL;
                end
            end
            ST_PENDING_STALL: begin
                if (!stall) begin
                    state_nxt = ST_PENDING;
                end
            end
            ST_DRAIN: begin
                if (!stall) begin
                    state_nxt = ST_HALT;
                end
            end
            default: state_nxt = state;
        endcase
        if (take_redirect) begin
            state_nxt = ST_REQ;
        end
        if (halt) begin
            state_nxt = ST_DRAIN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next request goes out in the same cycle the previous one is handed on
    assign fe_req.valid = (state == ST_REQ
                           || (state == ST_PENDING && mem_rsp.valid && !stall)
                           || (state == ST_PENDING_STALL && !stall))
                          && !take_redirect && !halt;
    assign fe_req.addr  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= t_paddr'(`FE_RESET_PC);
        end else if (take_redirect) begin
            pc <= redirect_pc;
        end else if (fe_req.valid) begin
            pc <= pc + t_paddr'(4);
        end
    end

    // Replay copy for a response that arrives under stall
    always_ff @(posedge clk) begin
        if (mem_rsp.valid) begin
            hold_pkt <= live_pkt;
        end
    end

    assign fe_valid = ((state == ST_PENDING && mem_rsp.valid) || state == ST_PENDING_STALL)
                      && !take_redirect && !halt;
    assign fe_pkt   = (state == ST_PENDING) ? live_pkt : hold_pkt;
    assign halted   = state == ST_HALT;

endmodule

/* fetch/instr_mem.sv */
`include "fe_macros.svh"

module instr_mem (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_en,
    input  fe_pkg::t_paddr   load_addr,
    input  logic [31:0]      load_data,
    input  fe_pkg::t_fe_req  fe_req,
    output fe_pkg::t_mem_rsp mem_rsp
);
    import fe_pkg::*;

    localparam int IDX_W = $clog2(`FE_MEM_WORDS);

    logic [31:0]      mem [`FE_MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             rsp_valid;
    t_paddr           rsp_pc;
    logic [31:0]      rsp_instr;

    // Word index, byte offset dropped
    assign rd_idx = fe_req.addr[IDX_W+1:2];
    assign wr_idx = load_addr[IDX_W+1:2];

    // Load port, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_idx] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fe_req.valid;
        end
    end

    // Read data and its address come back together next cycle
    always_ff @(posedge clk) begin
        if (fe_req.valid) begin
            rsp_pc    <= fe_req.addr;
            rsp_instr <= mem[rd_idx];
        end
    end

    assign mem_rsp.valid = rsp_valid;
    assign mem_rsp.pc    = rsp_pc;
    assign mem_rsp.instr = rsp_instr;

endmodule

/* verilog/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               fe_valid,
    input  fe_pkg::t_fetch_pkt fe_pkt,
    output logic               dec_valid,
    output fe_pkg::t_decoded   dec
);
    import fe_pkg::*;

    t_rv_i_view  iv;
    t_rv_sb_view sv;
    t_decoded    dec_nxt;
    logic        accept;

    assign iv = fe_pkt.instr.i_type;
    assign sv = fe_pkt.instr.sb_type;

    assign accept = fe_valid && !stall;

    always_comb begin
        dec_nxt.pc     = fe_pkt.pc;
        dec_nxt.opcode = iv.opcode;
        dec_nxt.rd     = iv.rd;
        dec_nxt.rs1    = iv.rs1;
        dec_nxt.funct3 = iv.funct3;
        // rs2 only exists in the S/B layout
        dec_nxt.rs2    = sv.rs2;

        case (iv.opcode)
            OP_LOAD, OP_OPIMM: begin
                dec_nxt.imm = {{20{iv.imm12[11]}}, iv.imm12};
            end
            OP_STORE: begin
                dec_nxt.imm = {{20{sv.imm_hi[6]}}, sv.imm_hi, sv.imm_lo};
            end
            OP_BRANCH: begin
                // imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
                dec_nxt.imm = {{19{sv.imm_hi[6]}}, sv.imm_hi[6], sv.imm_lo[0],
                               sv.imm_hi[5:0], sv.imm_lo[4:1], 1'b0};
            end
            OP_LUI: begin
                dec_nxt.imm = {iv.imm12, iv.rs1, iv.funct3, 12'b0};
            end
            OP_JAL: begin
                // Bits 31:12 hold imm[20|10:1|11|19:12]
                dec_nxt.imm = {{12{iv.imm12[11]}}, iv.rs1, iv.funct3,
                               iv.imm12[0], iv.imm12[10:1], 1'b0};
            end
            default: begin
                dec_nxt.imm = '0;
            end
        endcase
    end

    // Valid holds under stall, otherwise follows the accepted packet
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= fe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_nxt;
        end
    end

endmodule

/* verilog/frontend_top.sv */
module frontend_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect,
    input  fe_pkg::t_paddr   redirect_pc,
    input  logic             load_en,
    input  fe_pkg::t_paddr   load_addr,
    input  logic [31:0]      load_data,
    output logic             dec_valid,
    output fe_pkg::t_decoded dec,
    output logic             halted
);
    import fe_pkg::*;

    t_fe_req    fe_req;
    t_mem_rsp   mem_rsp;
    logic       fe_valid;
    t_fetch_pkt fe_pkt;

    fetch_ctl u_fetch_ctl (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fe_req      (fe_req),
        .mem_rsp     (mem_rsp),
        .fe_valid    (fe_valid),
        .halted      (halted),
        .fe_pkt      (fe_pkt)
    );

    instr_mem u_instr_mem (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fe_req    (fe_req),
        .mem_rsp   (mem_rsp)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .fe_valid  (fe_valid),
        .fe_pkt    (fe_pkt),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

endmodule

/* test/frontend_props.sv */
module frontend_props (
    input logic               clk,
    input logic               reset,
    input logic               take_redirect,
    input fe_pkg::t_paddr     redirect_pc,
    input fe_pkg::t_fe_req    fe_req,
    input logic               stall,
    input logic               fe_valid,
    input logic               halted,
    input fe_pkg::t_fetch_pkt fe_pkt
);
    timeunit 1ns;
    timeprecision 100ps;

    // Redirect drops whatever response is in flight and refetches from the target
    assert property (@(posedge clk) disable iff (reset)
        take_redirect |-> !fe_valid
            ##1 (take_redirect || (fe_req.valid && fe_req.addr == $past(redirect_pc))))
        else $error("redirect did not drop the response and refetch from the target");

    // Packet held for decode while it is stalled
    assert property (@(posedge clk) disable iff (reset) fe_valid && stall |=> $stable(fe_pkt))
        else $error("fe_pkt changed while stalled");

    assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind fetch_ctl frontend_props u_props (
    .clk           (clk),
    .reset         (reset),
    .take_redirect (take_redirect),
    .redirect_pc   (redirect_pc),
    .fe_req        (fe_req),
    .stall         (stall),
    .fe_valid      (fe_valid),
    .halted        (halted),
    .fe_pkt        (fe_pkt)
);

/* test/frontend_check.sv */
`include "fe_macros.svh"

module frontend_check (
    input logic             clk,
    input logic             reset,
    input logic             stall,
    input logic             redirect,
    input fe_pkg::t_paddr   redirect_pc,
    input logic             load_en,
    input fe_pkg::t_paddr   load_addr,
    input logic [31:0]      load_data,
    input logic             dec_valid,
    input fe_pkg::t_decoded dec,
    input logic             halted
);
    timeunit 1ns;
    timeprecision 100ps;
    import fe_pkg::*;

    logic [31:0] prog [`FE_MEM_WORDS];
    t_paddr      exp_pc;
    string       test_name;
    int          errors;
    int          checked;
    int          total_checked;
    int          tests_done;
    int          errors_at_start;

    // Field split and immediate rules of the base RV32I formats
    function automatic t_decoded ref_decode(input t_paddr pc, input logic [31:0] w);
        t_decoded d;
        d.pc     = pc;
        d.opcode = w[6:0];
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        case (w[6:0])
            OP_LOAD, OP_OPIMM: d.imm = {{20{w[31]}}, w[31:20]};
            OP_STORE:  d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            OP_BRANCH: d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OP_LUI:    d.imm = {w[31:12], 12'b0};
            OP_JAL:    d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:   d.imm = '0;
        endcase
        return d;
    endfunction

    // Shadow copy of the program from the load port
    always @(posedge clk) begin
        if (load_en) begin
            prog[load_addr >> 2] = load_data;
        end
    end

    always @(posedge clk) begin
        t_decoded want;
        if (reset) begin
            exp_pc = `FE_RESET_PC;
        end else begin
            if (dec_valid && halted) begin
                errors++;
                $display("%s: dec_valid is high after the halt", test_name);
            end
            if (dec_valid && !stall) begin
                want = ref_decode(exp_pc, prog[exp_pc >> 2]);
                if (want.opcode == OP_SYSTEM) begin
                    errors++;
                    $display("%s: SYSTEM instruction at pc %h reached decode", test_name, exp_pc);
                end else if (dec !== want) begin
                    errors++;
                    $display("Error %s: expected %h actual %h", test_name, want, dec);
                end
                checked++;
                total_checked++;
                exp_pc = exp_pc + 32'd4;
            end
            // The instruction already in decode comes before the target
            if (redirect) begin
                exp_pc = redirect_pc;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name       = name;
        checked         = 0;
        errors_at_start = errors;
    endtask

    task automatic end_test(input bit got_halt, input t_paddr sys_pc);
        if (!got_halt) begin
            errors++;
            $display("%s: halted did not rise", test_name);
        end
        if (exp_pc !== sys_pc) begin
            errors++;
            $display("Error %s: expected stream to stop at pc %h, actual %h",
                     test_name, sys_pc, exp_pc);
        end
        tests_done++;
        $display("%s finished: %0d instructions, %0d errors",
                 test_name, checked, errors - errors_at_start);
    endtask

endmodule

/* test/frontend_tb.sv */
module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fe_pkg::*;

    localparam int PROG_LEN    = 20;
    localparam int IMM_LEN     = 16;
    localparam int REDIR_IDX   = 14;
    localparam int CYCLE_LIMIT = (3 * PROG_LEN + IMM_LEN) * 40 + 500;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        redirect;
    t_paddr      redirect_pc;
    logic        load_en;
    t_paddr      load_addr;
    logic [31:0] load_data;
    logic        dec_valid;
    t_decoded    dec;
    logic        halted;

    logic [31:0] prog_buf [PROG_LEN];
    logic [31:0] imm_words [IMM_LEN];
    int          prog_n;
    logic [31:0] seed;
    logic        stall_rand;

    frontend_top u_dut (.*);
    frontend_check u_check (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [6:0] format_op(input int k);
        case (k % 7)
            0: return OP_LOAD;
            1: return OP_STORE;
            2: return OP_BRANCH;
            3: return OP_OPIMM;
            4: return OP_OP;
            5: return OP_LUI;
            default: return OP_JAL;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        #2;
        if (stall_rand) begin
            seed = xorshift(seed);
            stall = seed[0];
        end else begin
            stall = 1'b0;
        end
    end

    initial begin
        #(CYCLE_LIMIT * 20);
        $display("Watchdog timeout, the tests did not reach their end");
        $display("Errors found");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Program goes in while reset is held, then 4 more reset cycles
    task automatic load_and_reset();
        int i;
        reset = 1'b1;
        for (i = 0; i < prog_n; i++) begin
            next_cycle();
            load_en   = 1'b1;
            load_addr = t_paddr'(i * 4);
            load_data = prog_buf[i];
        end
        next_cycle();
        load_en = 1'b0;
        repeat (4) next_cycle();
        reset = 1'b0;
    endtask

    task automatic wait_halt(output bit got);
        int n;
        n = 0;
        while (!halted && n < prog_n * 40) begin
            next_cycle();
            n++;
        end
        got = halted;
        // Decode must stay quiet once halted
        repeat (10) next_cycle();
    endtask

    task automatic run_program(input string name, input bit with_redirect);
        bit got;
        u_check.begin_test(name);
        load_and_reset();
        if (with_redirect) begin
            while (u_check.checked < 3) begin
                next_cycle();
            end
            redirect    = 1'b1;
            redirect_pc = t_paddr'(REDIR_IDX * 4);
            next_cycle();
            redirect = 1'b0;
        end
        wait_halt(got);
        u_check.end_test(got, t_paddr'((prog_n - 1) * 4));
    endtask

    initial begin
        int i;
        int k;
        reset       = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        stall_rand  = 1'b0;
        seed        = 32'h3d3;
        // First seven cover every format, the rest are random
        for (i = 0; i < PROG_LEN - 1; i++) begin
            seed = xorshift(seed);
            k = (i < 7) ? i : int'(seed[2:0]);
            prog_buf[i] = {seed[31:7], format_op(k)};
        end
        prog_buf[PROG_LEN-1] = 32'h0000_0073;
        prog_n = PROG_LEN;
        // I: 2047, -2048, -1; S: -1, -2048, 2047; B: -4096, 4094, -2
        // U: 0xfffff, 0x80000; J: min, max, -2
        imm_words = '{32'h7FF00013, 32'h80000013, 32'hFFF02083, 32'hFE000FA3,
                      32'h80000023, 32'h7E000FA3, 32'h80000063, 32'h7E000FE3,
                      32'hFE000FE3, 32'hFFFFF037, 32'h80000037, 32'h8000006F,
                      32'h7FFFF06F, 32'hFFFFF06F, 32'h00000013, 32'h00000073};

        run_program("straight", 1'b0);
        stall_rand = 1'b1;
        run_program("random_stall", 1'b0);
        stall_rand = 1'b0;
        run_program("redirect", 1'b1);
        for (i = 0; i < IMM_LEN; i++) begin
            prog_buf[i] = imm_words[i];
        end
        prog_n = IMM_LEN;
        run_program("immediates", 1'b0);

        $display("Tests: %0d, instructions checked: %0d, errors: %0d",
                 u_check.tests_done, u_check.total_checked, u_check.errors);
        if (u_check.errors == 0 && u_check.tests_done == 4) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* frontend_top.f */
+incdir+common
common/fe_pkg.sv
fetch/fetch_ctl.sv
fetch/instr_mem.sv
verilog/decode_stage.sv
verilog/frontend_top.sv
test/frontend_props.sv
test/frontend_check.sv
test/frontend_tb.sv
